// ==== logic/cam_qspi_pkg.sv ====
// Shared types and constants for the camera to quad-SPI SRAM capture path.
// Every RTL block refers to these by scoped name.
`default_nettype none

package cam_qspi_pkg;

	// ----------------------------------------------------------------------
	// Vector types
	// ----------------------------------------------------------------------
	typedef logic [7:0]  cam_byte_t;	// One camera pixel byte
	typedef logic [31:0] word_t;		// Packed buffer word or register value
	typedef logic [3:0]  nibble_t;		// One quad-SPI beat
	typedef logic [23:0] qspi_addr_t;	// External SRAM byte address
	typedef logic [1:0]  wb_addr_t;		// Register address

	// ----------------------------------------------------------------------
	// Structs
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic  valid;	// One-cycle word strobe
		word_t data;	// First byte in bits 31:24
	} cam_word_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		word_t    dat;
		logic [2:0] spare;	// Held at 0
	} wb_req_t;

	typedef struct packed {
		logic    nce;	// Active-low chip select
		logic    oe;	// Pad output enable
		nibble_t dat;	// Data lines 3:0
	} qspi_pins_t;

	// Burst writer FSM
	typedef enum logic [2:0] {IDLE, CMD, ADDR, DATA, GAP} qspi_state_e;

	// ----------------------------------------------------------------------
	// Constants
	// ----------------------------------------------------------------------
	localparam logic [7:0] QSPI_CMD_WRITE  = 8'h38;		// Quad write command
	localparam qspi_addr_t QSPI_START_ADDR = 24'h000004;	// First burst target
	localparam int         QSPI_GAP_CYCLES = 2;			// nCE high time between bursts
	localparam wb_addr_t   REG_CTRL        = 2'd0;
	localparam wb_addr_t   REG_STATUS      = 2'd1;

endpackage

`default_nettype wire

// ==== logic/cam_byte_packer.sv ====
// Camera byte packer. Collects four accepted pixel bytes and emits one
// 32-bit word with a single-cycle valid strobe, first byte most significant.
`default_nettype none

module cam_byte_packer (
	input  wire logic                   WBs_CLK_i,
	input  wire logic                   WBs_RST_i,
	input  wire logic                   cam_href_i,
	input  wire logic                   cam_vsync_i,
	input  wire logic                   capture_en_i,
	input  wire cam_qspi_pkg::cam_byte_t cam_dat_i,
	output cam_qspi_pkg::cam_word_t     word_o
);

	logic                accept;		// Byte taken on this edge
	logic [1:0]          phase;		// Bytes held so far
	logic [23:0]         hold;		// First three bytes of a word
	logic                word_valid;
	cam_qspi_pkg::word_t word_data;

	assign accept = cam_href_i & cam_vsync_i & capture_en_i;

	// Phase counter and valid strobe
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			phase      <= 2'd0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;			// Pulse only
			if (!capture_en_i) begin
				phase <= 2'd0;			// Restart word alignment
			end else if (accept) begin
				phase <= phase + 2'd1;		// Wraps after fourth byte
				if (phase == 2'd3) begin
					word_valid <= 1'b1;
				end
			end
		end
	end

	// Byte shifter, no reset on payload
	always_ff @(posedge WBs_CLK_i) begin
		if (accept) begin
			hold <= {hold[15:0], cam_dat_i};	// Oldest byte moves up
			if (phase == 2'd3) begin
				word_data <= {hold, cam_dat_i};
			end
		end
	end

	assign word_o = '{valid: word_valid, data: word_data};

endmodule

`default_nettype wire

// ==== logic/frame_buffer.sv ====
// Circular word buffer between the camera packer and the quad-SPI writer.
// One credit per free slot. The writer hands a credit back with each read,
// and a word that arrives with no credit left is dropped and flagged.
`default_nettype none

module frame_buffer #(
	parameter int BUF_DEPTH   = 256,	// Power of two
	parameter int BURST_WORDS = 16		// Divides BUF_DEPTH
) (
	input  wire logic                    WBs_CLK_i,
	input  wire logic                    WBs_RST_i,
	input  wire cam_qspi_pkg::cam_word_t word_i,
	input  wire logic                    rd_en_i,
	input  wire logic                    credit_return_i,
	output cam_qspi_pkg::word_t          rd_data_o,
	output logic                         burst_avail_o,
	output logic [15:0]                  fill_o,
	input  wire logic                    overflow_clr_i,
	output logic                         overflow_o
);

	localparam int AW = $clog2(BUF_DEPTH);

	typedef logic [AW-1:0] ptr_t;	// Slot index
	typedef logic [AW:0]   cnt_t;	// Holds 0 to BUF_DEPTH

	localparam cnt_t DEPTH_CNT = cnt_t'(BUF_DEPTH);
	localparam cnt_t BURST_CNT = cnt_t'(BURST_WORDS);

	cam_qspi_pkg::word_t mem [BUF_DEPTH];
	ptr_t  wr_ptr;
	ptr_t  rd_ptr;
	cnt_t  credits;		// Free slots
	cnt_t  credits_nxt;
	logic  store;

	assign store = word_i.valid && (credits != '0);

	always_comb begin
		credits_nxt = credits;
		if (store) credits_nxt = credits_nxt - cnt_t'(1);
		if (credit_return_i) credits_nxt = credits_nxt + cnt_t'(1);
	end

	// ----------------------------------------------------------------------
	// Pointers, credits and flags
	// ----------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			credits       <= DEPTH_CNT;		// Empty buffer
			burst_avail_o <= 1'b0;
			overflow_o    <= 1'b0;
		end else begin
			if (store) wr_ptr <= wr_ptr + ptr_t'(1);	// Wraps at depth
			if (rd_en_i) rd_ptr <= rd_ptr + ptr_t'(1);
			credits       <= credits_nxt;
			burst_avail_o <= (DEPTH_CNT - credits_nxt) >= BURST_CNT;
			if (word_i.valid && (credits == '0)) begin
				overflow_o <= 1'b1;			// Sticky, set wins
			end else if (overflow_clr_i) begin
				overflow_o <= 1'b0;
			end
		end
	end

	// Storage and registered read port
	always_ff @(posedge WBs_CLK_i) begin
		if (store) mem[wr_ptr] <= word_i.data;
		if (rd_en_i) rd_data_o <= mem[rd_ptr];	// Valid next cycle
	end

	assign fill_o = 16'(DEPTH_CNT - credits);	// Stored, not yet read

endmodule

`default_nettype wire

// ==== logic/qspi_burst_writer.sv ====
// Quad-SPI burst writer. Sends the write command one bit per cycle on
// line 0, then a 24-bit address and BURST_WORDS buffered words as nibbles,
// releases chip select for a short gap, and waits for the next burst.
`default_nettype none

module qspi_burst_writer #(
	parameter int BURST_WORDS = 16
) (
	input  wire logic                WBs_CLK_i,
	input  wire logic                WBs_RST_i,
	input  wire logic                stream_en_i,
	input  wire logic                burst_avail_i,
	output logic                     rd_en_o,
	output logic                     credit_return_o,
	input  wire cam_qspi_pkg::word_t rd_data_i,
	output cam_qspi_pkg::qspi_pins_t qspi_o
);

	localparam int DATA_BEATS = 8 * BURST_WORDS;	// Nibbles per burst
	localparam int CNT_W      = $clog2(DATA_BEATS);

	typedef logic [CNT_W-1:0] beat_t;

	localparam beat_t CMD_LAST  = beat_t'(7);
	localparam beat_t ADDR_RD   = beat_t'(3);	// Fetch of first word
	localparam beat_t ADDR_LOAD = beat_t'(4);
	localparam beat_t ADDR_LAST = beat_t'(5);
	localparam beat_t DATA_LAST = beat_t'(DATA_BEATS - 1);
	localparam beat_t DATA_MORE = beat_t'(DATA_BEATS - 8);	// Below this, a word follows
	localparam beat_t GAP_LAST  = beat_t'(cam_qspi_pkg::QSPI_GAP_CYCLES - 1);
	localparam cam_qspi_pkg::qspi_addr_t BURST_BYTES =
		cam_qspi_pkg::qspi_addr_t'(4 * BURST_WORDS);

	cam_qspi_pkg::qspi_state_e state;
	beat_t                      beat;		// Index of beat on the pins
	cam_qspi_pkg::qspi_pins_t   pins_q;
	cam_qspi_pkg::qspi_addr_t   burst_addr;	// Target of next burst
	cam_qspi_pkg::qspi_addr_t   addr_sr;
	logic [7:0]                 cmd_sr;
	cam_qspi_pkg::word_t        data_sr;	// Next nibble in bits 31:28
	logic                       more_words;
	logic                       load_next;

	assign more_words = beat < DATA_MORE;
	assign load_next  = (beat[2:0] == 3'd6) && more_words;

	// Word fetch two beats ahead of its first nibble
	assign rd_en_o = ((state == cam_qspi_pkg::ADDR) && (beat == ADDR_RD)) ||
		((state == cam_qspi_pkg::DATA) && (beat[2:0] == 3'd5) && more_words);
	assign credit_return_o = rd_en_o;	// Slot freed once read

	// ----------------------------------------------------------------------
	// FSM and pin register
	// ----------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state      <= cam_qspi_pkg::IDLE;
			beat       <= '0;
			burst_addr <= cam_qspi_pkg::QSPI_START_ADDR;
			pins_q     <= '{nce: 1'b1, oe: 1'b1, dat: 4'h0};	// oe held, write only
		end else begin
			case (state)
			cam_qspi_pkg::IDLE: begin
				if (stream_en_i && burst_avail_i) begin
					state      <= cam_qspi_pkg::CMD;
					beat       <= '0;
					burst_addr <= burst_addr + BURST_BYTES;	// Wraps at 24 bits
					pins_q.nce <= 1'b0;
					pins_q.dat <= {3'b000, cam_qspi_pkg::QSPI_CMD_WRITE[7]};
				end
			end
			cam_qspi_pkg::CMD: begin
				if (beat == CMD_LAST) begin
					state      <= cam_qspi_pkg::ADDR;
					beat       <= '0;
					pins_q.dat <= addr_sr[23:20];
				end else begin
					beat       <= beat + beat_t'(1);
					pins_q.dat <= {3'b000, cmd_sr[7]};	// Line 0 only
				end
			end
			cam_qspi_pkg::ADDR: begin
				if (beat == ADDR_LAST) begin
					state      <= cam_qspi_pkg::DATA;
					beat       <= '0;
					pins_q.dat <= data_sr[31:28];
				end else begin
					beat       <= beat + beat_t'(1);
					pins_q.dat <= addr_sr[23:20];
				end
			end
			cam_qspi_pkg::DATA: begin
				if (beat == DATA_LAST) begin
					state      <= cam_qspi_pkg::GAP;
					beat       <= '0;
					pins_q.nce <= 1'b1;			// End of burst
					pins_q.dat <= 4'h0;
				end else begin
					beat       <= beat + beat_t'(1);
					pins_q.dat <= data_sr[31:28];
				end
			end
			cam_qspi_pkg::GAP: begin
				if (beat == GAP_LAST) begin
					state <= cam_qspi_pkg::IDLE;
					beat  <= '0;
				end else begin
					beat <= beat + beat_t'(1);
				end
			end
			default: state <= cam_qspi_pkg::IDLE;
			endcase
		end
	end

	// Shift registers feeding the pins
	always_ff @(posedge WBs_CLK_i) begin
		case (state)
		cam_qspi_pkg::IDLE: begin
			cmd_sr  <= {cam_qspi_pkg::QSPI_CMD_WRITE[6:0], 1'b0};
			addr_sr <= burst_addr;
		end
		cam_qspi_pkg::CMD: begin
			if (beat == CMD_LAST) addr_sr <= {addr_sr[19:0], 4'h0};
			else cmd_sr <= {cmd_sr[6:0], 1'b0};
		end
		cam_qspi_pkg::ADDR: begin
			if (beat != ADDR_LAST) addr_sr <= {addr_sr[19:0], 4'h0};
			if (beat == ADDR_LOAD) data_sr <= rd_data_i;	// First word
			else if (beat == ADDR_LAST) data_sr <= {data_sr[27:0], 4'h0};
		end
		cam_qspi_pkg::DATA: begin
			data_sr <= load_next ? rd_data_i : {data_sr[27:0], 4'h0};
		end
		default: ;
		endcase
	end

	assign qspi_o = pins_q;

endmodule

`default_nettype wire

// ==== logic/wb_ctrl_regs.sv ====
// Wishbone register block. CTRL holds capture and stream enables and
// issues the overflow clear pulse; STATUS reports overflow, VSYNC, writer
// busy and the buffer fill level. Ack is a one-shot one cycle after strobe.
`default_nettype none

module wb_ctrl_regs (
	input  wire logic                  WBs_CLK_i,
	input  wire logic                  WBs_RST_i,
	input  wire cam_qspi_pkg::wb_req_t wb_i,
	output cam_qspi_pkg::word_t        wb_dat_o,
	output logic                       wb_ack_o,
	input  wire logic                  cam_vsync_i,
	input  wire logic                  overflow_i,
	input  wire logic                  busy_i,
	input  wire logic [15:0]           fill_i,
	output logic                       capture_en_o,
	output logic                       stream_en_o,
	output logic                       overflow_clr_o
);

	logic req;		// New access, not yet acked
	logic ctrl_wr;

	assign req     = wb_i.cyc & wb_i.stb & ~wb_ack_o;
	assign ctrl_wr = req & wb_i.we & (wb_i.adr == cam_qspi_pkg::REG_CTRL);

	// ----------------------------------------------------------------------
	// Ack and CTRL register
	// ----------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wb_ack_o       <= 1'b0;
			capture_en_o   <= 1'b0;
			stream_en_o    <= 1'b0;
			overflow_clr_o <= 1'b0;
		end else begin
			wb_ack_o       <= req;			// Single cycle
			overflow_clr_o <= ctrl_wr & wb_i.dat[2];	// Not stored
			if (ctrl_wr) begin
				capture_en_o <= wb_i.dat[0];
				stream_en_o  <= wb_i.dat[1];
			end
		end
	end

	// Read mux, held stable by the master while ack is high
	always_comb begin
		case (wb_i.adr)
		cam_qspi_pkg::REG_CTRL: begin
			wb_dat_o = {30'h0, stream_en_o, capture_en_o};
		end
		cam_qspi_pkg::REG_STATUS: begin
			wb_dat_o = {fill_i, 13'h0, busy_i, cam_vsync_i, overflow_i};
		end
		default: begin
			wb_dat_o = '0;			// Unused addresses
		end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/cam_qspi_top.sv ====
// Top level of the camera capture and quad-SPI streaming path. Connects
// the packer, frame buffer, burst writer and Wishbone registers; all logic
// runs on the Wishbone clock.
`default_nettype none

module cam_qspi_top #(
	parameter int BUF_DEPTH   = 256,	// Buffer words, power of two
	parameter int BURST_WORDS = 16		// Words per quad-SPI burst
) (
	input  wire logic                    WBs_CLK_i,
	input  wire logic                    WBs_RST_i,
	input  wire cam_qspi_pkg::wb_req_t   wb_i,
	output cam_qspi_pkg::word_t          wb_dat_o,
	output logic                         wb_ack_o,
	input  wire logic                    cam_href_i,
	input  wire logic                    cam_vsync_i,
	input  wire cam_qspi_pkg::cam_byte_t cam_dat_i,
	output cam_qspi_pkg::qspi_pins_t     qspi_o
);

	cam_qspi_pkg::cam_word_t cam_word;	// Packer to buffer
	cam_qspi_pkg::word_t     rd_data;
	logic                    rd_en;
	logic                    credit_return;
	logic                    burst_avail;
	logic [15:0]             fill;
	logic                    overflow;
	logic                    overflow_clr;
	logic                    capture_en;
	logic                    stream_en;

	cam_byte_packer i_packer (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.cam_href_i   (cam_href_i),
		.cam_vsync_i  (cam_vsync_i),
		.capture_en_i (capture_en),
		.cam_dat_i    (cam_dat_i),
		.word_o       (cam_word)
	);

	frame_buffer #(
		.BUF_DEPTH   (BUF_DEPTH),
		.BURST_WORDS (BURST_WORDS)
	) i_buffer (
		.WBs_CLK_i       (WBs_CLK_i),
		.WBs_RST_i       (WBs_RST_i),
		.word_i          (cam_word),
		.rd_en_i         (rd_en),
		.credit_return_i (credit_return),
		.rd_data_o       (rd_data),
		.burst_avail_o   (burst_avail),
		.fill_o          (fill),
		.overflow_clr_i  (overflow_clr),
		.overflow_o      (overflow)
	);

	qspi_burst_writer #(
		.BURST_WORDS (BURST_WORDS)
	) i_writer (
		.WBs_CLK_i       (WBs_CLK_i),
		.WBs_RST_i       (WBs_RST_i),
		.stream_en_i     (stream_en),
		.burst_avail_i   (burst_avail),
		.rd_en_o         (rd_en),
		.credit_return_o (credit_return),
		.rd_data_i       (rd_data),
		.qspi_o          (qspi_o)
	);

	wb_ctrl_regs i_regs (
		.WBs_CLK_i      (WBs_CLK_i),
		.WBs_RST_i      (WBs_RST_i),
		.wb_i           (wb_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.cam_vsync_i    (cam_vsync_i),
		.overflow_i     (overflow),
		.busy_i         (~qspi_o.nce),	// Burst in progress
		.fill_i         (fill),
		.capture_en_o   (capture_en),
		.stream_en_o    (stream_en),
		.overflow_clr_o (overflow_clr)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_cam_qspi_assertions.sv ====
// Protocol assertions for the camera to quad-SPI top level.
// Bound into cam_qspi_top and watches the ack, the pins and the read strobe.
`default_nettype none

module tb_cam_qspi_assertions (
	input wire logic                     WBs_CLK_i,
	input wire logic                     WBs_RST_i,
	input wire logic                     wb_ack_i,
	input wire cam_qspi_pkg::qspi_pins_t qspi_i,
	input wire logic                     rd_en_i,
	input wire logic                     burst_avail_i
);

	logic [7:0] high_run;		// Cycles nCE has been high in a row
	logic       avail_seen;		// burst_avail at the last edge with nCE high
	int         assert_fails = 0;	// Failed assertion count

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			high_run <= 8'd0;
		end else if (!qspi_i.nce) begin
			high_run <= 8'd0;
		end else if (high_run != 8'hff) begin
			high_run <= high_run + 8'd1;	// Saturates
		end
	end

	// Latched on the IDLE edge that starts a burst, held while nCE is low
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			avail_seen <= 1'b0;
		end else if (qspi_i.nce) begin
			avail_seen <= burst_avail_i;
		end
	end

	// ----------------------------------------------------------------------
	// Wishbone and quad-SPI pin rules
	// ----------------------------------------------------------------------
	a_ack_one_shot: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wb_ack_i |=> !wb_ack_i)
		else begin
			$error("Wishbone ack high on two consecutive cycles");
			assert_fails++;
		end

	a_oe_held: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		qspi_i.oe)
		else begin
			$error("Quad-SPI output enable dropped");
			assert_fails++;
		end

	a_gap_kept: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$fell(qspi_i.nce) |-> (high_run >= 8'(cam_qspi_pkg::QSPI_GAP_CYCLES)))
		else begin
			$error("Chip select gap between bursts too short");
			assert_fails++;
		end

	// Reads only in a burst that began with a full burst stored
	a_read_avail: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		rd_en_i |-> avail_seen)
		else begin
			$error("Buffer read in a burst started without a full burst stored");
			assert_fails++;
		end

endmodule

bind cam_qspi_top tb_cam_qspi_assertions i_assertions (
	.WBs_CLK_i     (WBs_CLK_i),
	.WBs_RST_i     (WBs_RST_i),
	.wb_ack_i      (wb_ack_o),
	.qspi_i        (qspi_o),
	.rd_en_i       (rd_en),
	.burst_avail_i (burst_avail)
);

`default_nettype wire

// ==== testbench/tb_cam_qspi_top.sv ====
// Testbench for the camera capture and quad-SPI streaming top level.
// Drives random camera bytes and Wishbone accesses, decodes each quad-SPI
// burst and compares it with the words built from the offered bytes.
`default_nettype none

module tb_cam_qspi_top;

	localparam int BUF_DEPTH   = 32;
	localparam int BURST_WORDS = 4;
	localparam int BURST_BEATS = 14 + 8 * BURST_WORDS;	// Command, address, data
	localparam int WAIT_LIMIT  = 2000;

	logic                     WBs_CLK_i;
	logic                     WBs_RST_i;
	cam_qspi_pkg::wb_req_t    wb_req;
	cam_qspi_pkg::word_t      wb_dat;
	logic                     wb_ack;
	logic                     cam_href;
	logic                     cam_vsync;
	cam_qspi_pkg::cam_byte_t  cam_dat;
	cam_qspi_pkg::qspi_pins_t qspi;

	cam_qspi_pkg::word_t      exp_words[$];	// Captured but not yet on the pins
	cam_qspi_pkg::qspi_addr_t exp_addr;	// Next burst target
	int                       value_errors;
	int                       timeout_errors;
	int                       bursts_seen;
	int                       beat_idx;	// Beat within current burst
	logic [7:0]               cmd_acc;
	cam_qspi_pkg::qspi_addr_t addr_acc;
	cam_qspi_pkg::word_t      data_acc;

	cam_qspi_top #(
		.BUF_DEPTH   (BUF_DEPTH),
		.BURST_WORDS (BURST_WORDS)
	) i_dut (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.wb_i        (wb_req),
		.wb_dat_o    (wb_dat),
		.wb_ack_o    (wb_ack),
		.cam_href_i  (cam_href),
		.cam_vsync_i (cam_vsync),
		.cam_dat_i   (cam_dat),
		.qspi_o      (qspi)
	);

	initial begin
		WBs_CLK_i = 1'b0;
		forever #50 WBs_CLK_i = ~WBs_CLK_i;
	end

	// ----------------------------------------------------------------------
	// Checks and run control
	// ----------------------------------------------------------------------
	task automatic end_run();
		int assert_count;
		assert_count = i_dut.i_assertions.assert_fails;
		$display("Closing counts: %0d value errors, %0d timeouts, %0d assertion failures",
			value_errors, timeout_errors, assert_count);
		if (value_errors == 0 && timeout_errors == 0 && assert_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeout_errors++;
		$display("Timeout at %0t: %s", $time, what);
		end_run();
	endtask

	task automatic check_value(input string what, input cam_qspi_pkg::word_t got,
			input cam_qspi_pkg::word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s expected %08h, got %08h", $time, what, exp, got);
		end
	endtask

	task automatic take_word(input cam_qspi_pkg::word_t got);
		if (exp_words.size() == 0) begin
			value_errors++;
			$display("Error at %0t: quad-SPI word %08h with no captured word pending",
				$time, got);
		end else begin
			check_value("burst data word", got, exp_words.pop_front());
		end
	endtask

	// Quad-SPI decoder samples the stable pins on the falling edge
	always @(negedge WBs_CLK_i) begin
		if (!WBs_RST_i && !qspi.nce) begin
			if (beat_idx < 8) begin
				check_value("unused command lines", 32'(qspi.dat[3:1]), 32'h0);
				cmd_acc = {cmd_acc[6:0], qspi.dat[0]};	// Line 0 only
			end else if (beat_idx < 14) begin
				addr_acc = {addr_acc[19:0], qspi.dat};
			end else begin
				data_acc = {data_acc[27:0], qspi.dat};
				if ((beat_idx - 14) % 8 == 7) take_word(data_acc);	// Word complete
			end
			if (beat_idx == 13) begin
				check_value("write command", 32'(cmd_acc), 32'(cam_qspi_pkg::QSPI_CMD_WRITE));
				check_value("burst address", 32'(addr_acc), 32'(exp_addr));
			end
			beat_idx++;
		end else if (beat_idx != 0) begin
			check_value("beats per burst", 32'(beat_idx), 32'(BURST_BEATS));
			bursts_seen++;
			exp_addr = exp_addr + cam_qspi_pkg::qspi_addr_t'(4 * BURST_WORDS);
			beat_idx = 0;
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus tasks
	// ----------------------------------------------------------------------
	task automatic offer_byte(input logic href, input logic vsync,
			input cam_qspi_pkg::cam_byte_t b);
		@(negedge WBs_CLK_i);
		cam_href  = href;
		cam_vsync = vsync;
		cam_dat   = b;
	endtask

	task automatic camera_idle();
		offer_byte(1'b0, 1'b1, 8'h00);	// Line blank and frame active
	endtask

	task automatic offer_gated(input logic href, input logic vsync, input int count);
		repeat (count) offer_byte(href, vsync, cam_qspi_pkg::cam_byte_t'($urandom()));
	endtask

	task automatic push_word(input logic keep);
		cam_qspi_pkg::word_t     word;
		cam_qspi_pkg::cam_byte_t b;
		int                      i;
		word = '0;
		for (i = 0; i < 4; i++) begin
			b    = cam_qspi_pkg::cam_byte_t'($urandom());
			word = {word[23:0], b};	// First byte ends up on top
			offer_byte(1'b1, 1'b1, b);
		end
		if (keep) exp_words.push_back(word);
	endtask

	task automatic wb_access(input logic we, input cam_qspi_pkg::wb_addr_t adr,
			input cam_qspi_pkg::word_t wdata, output cam_qspi_pkg::word_t rdata);
		int waited;
		@(negedge WBs_CLK_i);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata, spare: 3'b000};
		waited = 0;
		do begin
			@(negedge WBs_CLK_i);
			waited++;
			if (waited > 16) report_timeout("Wishbone acknowledge never arrived");
		end while (!wb_ack);
		rdata  = wb_dat;	// Valid while ack is high
		wb_req = '0;
		@(negedge WBs_CLK_i);
		if (wb_ack) begin
			value_errors++;
			$display("Error at %0t: Wishbone ack stayed high for a second cycle", $time);
		end
	endtask

	task automatic wb_write(input cam_qspi_pkg::wb_addr_t adr, input cam_qspi_pkg::word_t wdata);
		cam_qspi_pkg::word_t unused;
		wb_access(1'b1, adr, wdata, unused);
	endtask

	task automatic wb_read_check(input cam_qspi_pkg::wb_addr_t adr,
			input cam_qspi_pkg::word_t exp, input string what);
		cam_qspi_pkg::word_t got;
		wb_access(1'b0, adr, 32'h0, got);
		check_value(what, got, exp);
	endtask

	// Decoder state only changes on the falling edge
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_words.size() != 0 || beat_idx != 0) begin
			@(posedge WBs_CLK_i);
			waited++;
			if (waited > WAIT_LIMIT) report_timeout("quad-SPI bursts stopped before all words came out");
		end
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		void'($urandom(19336));
		WBs_RST_i      = 1'b1;
		wb_req         = '0;
		cam_href       = 1'b0;
		cam_vsync      = 1'b0;
		cam_dat        = 8'h00;
		exp_addr       = cam_qspi_pkg::QSPI_START_ADDR;
		value_errors   = 0;
		timeout_errors = 0;
		bursts_seen    = 0;
		beat_idx       = 0;
		cmd_acc        = 8'h00;
		addr_acc       = '0;
		data_acc       = '0;
		repeat (4) @(posedge WBs_CLK_i);
		@(negedge WBs_CLK_i);
		WBs_RST_i = 1'b0;

		// Reset values and register access
		wb_read_check(cam_qspi_pkg::REG_STATUS, 32'h0, "STATUS after reset");
		camera_idle();	// Raises VSYNC
		wb_read_check(cam_qspi_pkg::REG_STATUS, 32'h2, "STATUS with VSYNC high");
		wb_write(cam_qspi_pkg::REG_CTRL, 32'h3);
		wb_read_check(cam_qspi_pkg::REG_CTRL, 32'h3, "CTRL readback");

		// First burst
		repeat (BURST_WORDS) push_word(1'b1);
		camera_idle();
		wait_drained();
		check_value("bursts after first frame", 32'(bursts_seen), 32'd1);

		// Address advance with gated bytes between words
		repeat (4) push_word(1'b1);
		offer_gated(1'b0, 1'b1, 3);	// HREF low
		repeat (4) push_word(1'b1);
		offer_gated(1'b1, 1'b0, 3);	// VSYNC low
		camera_idle();
		wb_write(cam_qspi_pkg::REG_CTRL, 32'h2);
		offer_gated(1'b1, 1'b1, 4);	// Capture off
		camera_idle();
		wb_write(cam_qspi_pkg::REG_CTRL, 32'h3);
		repeat (4) push_word(1'b1);
		camera_idle();
		wait_drained();
		check_value("bursts after address advance", 32'(bursts_seen), 32'd4);
		wb_read_check(cam_qspi_pkg::REG_STATUS, 32'h2, "STATUS after draining");

		// Credit exhaustion drops words past the buffer depth
		wb_write(cam_qspi_pkg::REG_CTRL, 32'h1);
		for (int n = 0; n < 40; n++) begin
			push_word(n < BUF_DEPTH);
		end
		camera_idle();
		repeat (4) @(negedge WBs_CLK_i);
		wb_read_check(cam_qspi_pkg::REG_STATUS, {16'(BUF_DEPTH), 16'h0003},
			"STATUS with buffer full");
		wb_write(cam_qspi_pkg::REG_CTRL, 32'h3);
		wait_drained();
		check_value("bursts after buffer drain", 32'(bursts_seen), 32'd12);
		wb_write(cam_qspi_pkg::REG_CTRL, 32'h7);
		wb_read_check(cam_qspi_pkg::REG_STATUS, 32'h2, "STATUS after overflow clear");
		wb_read_check(cam_qspi_pkg::REG_CTRL, 32'h3, "CTRL after overflow clear");
		repeat (100) @(negedge WBs_CLK_i);	// No stray burst may follow
		end_run();
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/cam_qspi_pkg.sv
logic/cam_byte_packer.sv
logic/frame_buffer.sv
logic/qspi_burst_writer.sv
logic/wb_ctrl_regs.sv
logic/cam_qspi_top.sv
testbench/tb_cam_qspi_assertions.sv
testbench/tb_cam_qspi_top.sv

// ==== Makefile ====
TOP := tb_cam_qspi_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
